/* Makefile */
SIMDIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the accCore testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f accCore.f \
		--top-module accCore_tb -Mdir $(SIMDIR)
	./$(SIMDIR)/VaccCore_tb | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf $(SIMDIR)

/* accCore.f */
+incdir+common
common/accCorePkg.sv
decode/instrDecode.sv
hdl/fetchUnit.sv
hdl/regFile.sv
hdl/alu.sv
hdl/accCore.sv
verification/clockGen.sv
verification/accCore_props.sv
verification/accCore_tb.sv

/* common/accCorePkg.sv */
`include "accCore_config.svh"

package accCorePkg;

  // set immediate view, opFlag low
  typedef struct packed {
    logic                   opFlag;
    logic [`ACC_DATA_W-1:0] imm;
  } immView_t;

  // operation view, opFlag high
  typedef struct packed {
    logic       opFlag;
    logic [5:0] opcode;
    logic [1:0] arg;
  } opView_t;

  // one 9-bit word, read either way depending on bit 8
  typedef union packed {
    immView_t immView;
    opView_t  opView;
  } instrWord_t;

  // register select, isReg high for t registers, low for accumulators
  typedef struct packed {
    logic                      isReg;
    logic [`ACC_REG_IDX_W-1:0] idx;
  } regSel_t;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SRL,
    ALU_SRA
  } aluOp_t;

  // write-back data source
  typedef enum logic [1:0] {
    SRC_ALU,
    SRC_IMM,
    SRC_MEM,
    SRC_READ1
  } regSrc_t;

  // full control word for one instruction
  typedef struct packed {
    regSel_t                read1;
    regSel_t                read2;
    logic                   writeEn;
    regSel_t                writeReg;
    regSrc_t                regSrc;
    aluOp_t                 aluOp;
    logic [`ACC_DATA_W-1:0] imm;
    logic                   memWrite;
    logic                   isBranch;
    logic [1:0]             brIdx;
    logic                   halt;
  } ctrlWord_t;

endpackage

/* common/accCore_config.svh */
`ifndef ACC_CORE_CONFIG_SVH
`define ACC_CORE_CONFIG_SVH

// datapath and instruction sizes
`define ACC_DATA_W     8
`define ACC_INSTR_W    9
`define ACC_PC_W       8
`define ACC_REG_IDX_W  3

// register counts, t0..t3 and acc0..acc5
`define ACC_NUM_T      4
`define ACC_NUM_ACC    6

// opcodes, instruction bits 7..2 when bit 8 is set
`define ACC_OPC_LDM0   6'b000000
`define ACC_OPC_LDM1   6'b000001
`define ACC_OPC_LDM2   6'b000010
`define ACC_OPC_LDM3   6'b000011
`define ACC_OPC_LDM4   6'b000100
`define ACC_OPC_LDR1   6'b000101
`define ACC_OPC_LDR4   6'b000110
`define ACC_OPC_LDR5   6'b000111
`define ACC_OPC_ADD1   6'b001000
`define ACC_OPC_ADD4   6'b001001
`define ACC_OPC_ADD5   6'b001010
`define ACC_OPC_SUB1   6'b001101
`define ACC_OPC_SUB3   6'b001110
`define ACC_OPC_SUB4   6'b001111
`define ACC_OPC_SUB5   6'b010000
`define ACC_OPC_STR1   6'b010010
`define ACC_OPC_STR2   6'b010011
`define ACC_OPC_STR3   6'b010100
`define ACC_OPC_STM0   6'b010101
`define ACC_OPC_STM1   6'b010110
`define ACC_OPC_STM3   6'b010111
`define ACC_OPC_STM4   6'b011000
`define ACC_OPC_STM5   6'b011001
`define ACC_OPC_MOV    6'b011010
`define ACC_OPC_SRL    6'b011011
`define ACC_OPC_SRA    6'b011100
`define ACC_OPC_BNZR   6'b011110
`define ACC_OPC_HALT   6'b110110

// branch lookup table, selected by the 2-bit arg of bnzr
`define ACC_BR_TARGET0 8'h10
`define ACC_BR_TARGET1 8'h20
`define ACC_BR_TARGET2 8'h30
`define ACC_BR_TARGET3 8'h04

`endif

/* decode/instrDecode.sv */
`timescale 1ns/1ns
`include "accCore_config.svh"

module instrDecode (
  input  logic                   rst,
  input  logic                   halted,
  input  accCorePkg::instrWord_t instr,
  output accCorePkg::ctrlWord_t  ctrl
);

  logic [1:0] arg;

  // t register operand named by the low two bits
  assign arg = instr.opView.arg;

  function automatic accCorePkg::regSel_t tSel(input logic [1:0] n);
    accCorePkg::regSel_t s;
    s.isReg = 1'b1;
    s.idx = {1'b0, n};
    return s;
  endfunction

  function automatic accCorePkg::regSel_t accSel(input logic [2:0] n);
    accCorePkg::regSel_t s;
    s.isReg = 1'b0;
    s.idx = n;
    return s;
  endfunction

  // acc_n gets t_arg from memory (SRC_MEM) or from the register itself (SRC_READ1)
  function automatic accCorePkg::ctrlWord_t loadCtrl(input accCorePkg::regSrc_t src,
                                                     input logic [2:0] n, input logic [1:0] a);
    accCorePkg::ctrlWord_t c;
    c = '0;
    c.read1 = tSel(a);
    c.writeEn = 1'b1;
    c.writeReg = accSel(n);
    c.regSrc = src;
    return c;
  endfunction

  // acc_n = acc_n op t_arg
  function automatic accCorePkg::ctrlWord_t accAluCtrl(input accCorePkg::aluOp_t op,
                                                       input logic [2:0] n, input logic [1:0] a);
    accCorePkg::ctrlWord_t c;
    c = '0;
    c.read1 = accSel(n);
    c.read2 = tSel(a);
    c.writeEn = 1'b1;
    c.writeReg = accSel(n);
    c.aluOp = op;
    return c;
  endfunction

  // t_arg = src register, mov and str share this
  function automatic accCorePkg::ctrlWord_t copyCtrl(input accCorePkg::regSel_t src,
                                                     input logic [1:0] a);
    accCorePkg::ctrlWord_t c;
    c = '0;
    c.read1 = src;
    c.writeEn = 1'b1;
    c.writeReg = tSel(a);
    c.regSrc = accCorePkg::SRC_READ1;
    return c;
  endfunction

  // mem[t_arg] = acc_n, address on read1 and data on read2
  function automatic accCorePkg::ctrlWord_t storeCtrl(input logic [2:0] n, input logic [1:0] a);
    accCorePkg::ctrlWord_t c;
    c = '0;
    c.read1 = tSel(a);
    c.read2 = accSel(n);
    c.memWrite = 1'b1;
    return c;
  endfunction

  // in-place shift of t_arg
  function automatic accCorePkg::ctrlWord_t shiftCtrl(input accCorePkg::aluOp_t op,
                                                      input logic [1:0] a);
    accCorePkg::ctrlWord_t c;
    c = '0;
    c.read1 = tSel(a);
    c.writeEn = 1'b1;
    c.writeReg = tSel(a);
    c.aluOp = op;
    return c;
  endfunction

  always_comb begin
    ctrl = '0;
    if (!instr.immView.opFlag) begin
      // set immediate always lands in t0
      ctrl.writeEn = 1'b1;
      ctrl.writeReg = tSel(2'd0);
      ctrl.regSrc = accCorePkg::SRC_IMM;
      ctrl.imm = instr.immView.imm;
    end else begin
      case (instr.opView.opcode)
        `ACC_OPC_LDM0: ctrl = loadCtrl(accCorePkg::SRC_MEM, 3'd0, arg);
        `ACC_OPC_LDM1: ctrl = loadCtrl(accCorePkg::SRC_MEM, 3'd1, arg);
        `ACC_OPC_LDM2: ctrl = loadCtrl(accCorePkg::SRC_MEM, 3'd2, arg);
        `ACC_OPC_LDM3: ctrl = loadCtrl(accCorePkg::SRC_MEM, 3'd3, arg);
        `ACC_OPC_LDM4: ctrl = loadCtrl(accCorePkg::SRC_MEM, 3'd4, arg);
        `ACC_OPC_LDR1: ctrl = loadCtrl(accCorePkg::SRC_READ1, 3'd1, arg);
        `ACC_OPC_LDR4: ctrl = loadCtrl(accCorePkg::SRC_READ1, 3'd4, arg);
        `ACC_OPC_LDR5: ctrl = loadCtrl(accCorePkg::SRC_READ1, 3'd5, arg);
        `ACC_OPC_ADD1: ctrl = accAluCtrl(accCorePkg::ALU_ADD, 3'd1, arg);
        `ACC_OPC_ADD4: ctrl = accAluCtrl(accCorePkg::ALU_ADD, 3'd4, arg);
        `ACC_OPC_ADD5: ctrl = accAluCtrl(accCorePkg::ALU_ADD, 3'd5, arg);
        `ACC_OPC_SUB1: ctrl = accAluCtrl(accCorePkg::ALU_SUB, 3'd1, arg);
        `ACC_OPC_SUB3: ctrl = accAluCtrl(accCorePkg::ALU_SUB, 3'd3, arg);
        `ACC_OPC_SUB4: ctrl = accAluCtrl(accCorePkg::ALU_SUB, 3'd4, arg);
        `ACC_OPC_SUB5: ctrl = accAluCtrl(accCorePkg::ALU_SUB, 3'd5, arg);
        `ACC_OPC_STR1: ctrl = copyCtrl(accSel(3'd1), arg);
        `ACC_OPC_STR2: ctrl = copyCtrl(accSel(3'd2), arg);
        `ACC_OPC_STR3: ctrl = copyCtrl(accSel(3'd3), arg);
        `ACC_OPC_MOV:  ctrl = copyCtrl(tSel(2'd0), arg);
        `ACC_OPC_STM0: ctrl = storeCtrl(3'd0, arg);
        `ACC_OPC_STM1: ctrl = storeCtrl(3'd1, arg);
        `ACC_OPC_STM3: ctrl = storeCtrl(3'd3, arg);
        `ACC_OPC_STM4: ctrl = storeCtrl(3'd4, arg);
        `ACC_OPC_STM5: ctrl = storeCtrl(3'd5, arg);
        `ACC_OPC_SRL:  ctrl = shiftCtrl(accCorePkg::ALU_SRL, arg);
        `ACC_OPC_SRA:  ctrl = shiftCtrl(accCorePkg::ALU_SRA, arg);
        `ACC_OPC_BNZR: begin
          // t0 tested on read1, arg picks the table entry
          ctrl.read1 = tSel(2'd0);
          ctrl.isBranch = 1'b1;
          ctrl.brIdx = arg;
        end
        `ACC_OPC_HALT: ctrl.halt = 1'b1;
        // unknown opcodes fall through as no-op
        default: ctrl = '0;
      endcase
    end
    // no side effects in reset or after halt
    if (rst || halted) begin
      ctrl.memWrite = 1'b0;
      ctrl.writeEn = 1'b0;
    end
  end

endmodule

/* hdl/accCore.sv */
`timescale 1ns/1ns
`include "accCore_config.svh"

module accCore (
  input  logic                   clk,
  input  logic                   rst,
  input  accCorePkg::instrWord_t instr,
  input  logic [`ACC_DATA_W-1:0] memRdData,
  output logic [`ACC_PC_W-1:0]   pc,
  output logic [`ACC_DATA_W-1:0] memAddr,
  output logic [`ACC_DATA_W-1:0] memWrData,
  output logic                   memWrite,
  output logic                   halted
);

  accCorePkg::ctrlWord_t  ctrl;
  logic [`ACC_DATA_W-1:0] rdData1;
  logic [`ACC_DATA_W-1:0] rdData2;
  logic [`ACC_DATA_W-1:0] aluResult;

  // stores use t_arg as address and the accumulator as data
  assign memAddr = rdData1;
  assign memWrData = rdData2;
  assign memWrite = ctrl.memWrite;

  instrDecode instrDecode_i (
    .rst    (rst),
    .halted (halted),
    .instr  (instr),
    .ctrl   (ctrl)
  );

  fetchUnit fetchUnit_i (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .rdData1 (rdData1),
    .pc      (pc),
    .halted  (halted)
  );

  regFile regFile_i (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .aluResult (aluResult),
    .memRdData (memRdData),
    .rdData1   (rdData1),
    .rdData2   (rdData2)
  );

  alu alu_i (
    .ctrl      (ctrl),
    .rdData1   (rdData1),
    .rdData2   (rdData2),
    .aluResult (aluResult)
  );

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ns
`include "accCore_config.svh"

module alu (
  input  accCorePkg::ctrlWord_t  ctrl,
  input  logic [`ACC_DATA_W-1:0] rdData1,
  input  logic [`ACC_DATA_W-1:0] rdData2,
  output logic [`ACC_DATA_W-1:0] aluResult
);

  logic [`ACC_DATA_W-1:0] sum;
  logic [`ACC_DATA_W-1:0] diff;

  // wraps modulo 256, no carry kept
  assign sum = rdData1 + rdData2;
  assign diff = rdData1 - rdData2;

  always_comb begin
    case (ctrl.aluOp)
      accCorePkg::ALU_ADD: begin
        aluResult = sum;
      end
      accCorePkg::ALU_SUB: begin
        aluResult = diff;
      end
      accCorePkg::ALU_SRL: begin
        // zero fill from the top
        aluResult = {1'b0, rdData1[`ACC_DATA_W-1:1]};
      end
      accCorePkg::ALU_SRA: begin
        // sign bit copied down
        aluResult = {rdData1[`ACC_DATA_W-1], rdData1[`ACC_DATA_W-1:1]};
      end
    endcase
  end

endmodule

/* hdl/fetchUnit.sv */
`timescale 1ns/1ns
`include "accCore_config.svh"

module fetchUnit (
  input  logic                   clk,
  input  logic                   rst,
  input  accCorePkg::ctrlWord_t  ctrl,
  input  logic [`ACC_DATA_W-1:0] rdData1,
  output logic [`ACC_PC_W-1:0]   pc,
  output logic                   halted
);

  // fixed branch targets, indexed by brIdx
  localparam logic [`ACC_PC_W-1:0] brTable [4] = '{
    `ACC_BR_TARGET0,
    `ACC_BR_TARGET1,
    `ACC_BR_TARGET2,
    `ACC_BR_TARGET3
  };

  logic brTaken;

  // bnzr tests t0, which sits on read port 1
  assign brTaken = ctrl.isBranch && (rdData1 != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
      halted <= 1'b0;
    end else if (!halted) begin
      if (ctrl.halt) begin
        // pc stays on the halt word
        halted <= 1'b1;
      end else if (brTaken) begin
        pc <= brTable[ctrl.brIdx];
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ns
`include "accCore_config.svh"

module regFile (
  input  logic                   clk,
  input  logic                   rst,
  input  accCorePkg::ctrlWord_t  ctrl,
  input  logic [`ACC_DATA_W-1:0] aluResult,
  input  logic [`ACC_DATA_W-1:0] memRdData,
  output logic [`ACC_DATA_W-1:0] rdData1,
  output logic [`ACC_DATA_W-1:0] rdData2
);

  // t0..t3 and acc0..acc5
  logic [`ACC_DATA_W-1:0] tRegs   [`ACC_NUM_T];
  logic [`ACC_DATA_W-1:0] accRegs [`ACC_NUM_ACC];
  logic [`ACC_DATA_W-1:0] wrData;

  // unmapped indices read as zero
  function automatic logic [`ACC_DATA_W-1:0] readReg(input accCorePkg::regSel_t sel);
    logic [`ACC_DATA_W-1:0] val;
    val = '0;
    if (sel.isReg) begin
      if (!sel.idx[2]) begin
        val = tRegs[sel.idx[1:0]];
      end
    end else if (sel.idx < `ACC_NUM_ACC) begin
      val = accRegs[sel.idx];
    end
    return val;
  endfunction

  // two combinational read ports
  always_comb begin
    rdData1 = readReg(ctrl.read1);
    rdData2 = readReg(ctrl.read2);
  end

  // write-back source select
  always_comb begin
    case (ctrl.regSrc)
      accCorePkg::SRC_ALU:   wrData = aluResult;
      accCorePkg::SRC_IMM:   wrData = ctrl.imm;
      accCorePkg::SRC_MEM:   wrData = memRdData;
      accCorePkg::SRC_READ1: wrData = rdData1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ACC_NUM_T; i++) begin
        tRegs[i] <= '0;
      end
      for (int i = 0; i < `ACC_NUM_ACC; i++) begin
        accRegs[i] <= '0;
      end
    end else if (ctrl.writeEn) begin
      if (ctrl.writeReg.isReg) begin
        if (!ctrl.writeReg.idx[2]) begin
          tRegs[ctrl.writeReg.idx[1:0]] <= wrData;
        end
      end else if (ctrl.writeReg.idx < `ACC_NUM_ACC) begin
        accRegs[ctrl.writeReg.idx] <= wrData;
      end
    end
  end

endmodule

/* verification/accCore_props.sv */
`timescale 1ns/1ns
`include "accCore_config.svh"

module accCore_props (
  input logic                   clk,
  input logic                   rst,
  input logic [`ACC_INSTR_W-1:0] instr,
  input logic [`ACC_PC_W-1:0]   pc,
  input logic                   memWrite,
  input logic                   halted
);

  logic brOrHalt;
  // assertion failures seen so far
  int errorCount = 0;

  // branch and halt are the only words that break pc+1
  assign brOrHalt = instr[8] &&
                    ((instr[7:2] == `ACC_OPC_BNZR) || (instr[7:2] == `ACC_OPC_HALT));

  noStoreInReset: assert property (@(posedge clk) rst |-> !memWrite)
    else begin
      $error("memWrite high during reset");
      errorCount++;
    end

  pcClearedByReset: assert property (@(posedge clk) rst |=> pc == '0)
    else begin
      $error("pc not cleared after reset");
      errorCount++;
    end

  haltSticks: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted && $stable(pc) && !memWrite)
    else begin
      $error("halted state did not hold");
      errorCount++;
    end

  noStoreWhenHalted: assert property (@(posedge clk) halted |-> !memWrite)
    else begin
      $error("memWrite high while halted");
      errorCount++;
    end

  // plain sequential flow
  pcIncrements: assert property (@(posedge clk) disable iff (rst)
    !halted && !brOrHalt |=> pc == ($past(pc) + 8'd1))
    else begin
      $error("pc did not advance by one");
      errorCount++;
    end

endmodule

bind accCore accCore_props accCore_props_i (
  .clk      (clk),
  .rst      (rst),
  .instr    (instr),
  .pc       (pc),
  .memWrite (memWrite),
  .halted   (halted)
);

/* verification/accCore_tb.sv */
`timescale 1ns/1ns
`include "accCore_config.svh"

module accCore_tb;

  logic clk;
  logic porRst;
  logic tbRst;
  logic rst;
  accCorePkg::instrWord_t instr;
  logic [7:0] memRdData;
  logic [7:0] pc;
  logic [7:0] memAddr;
  logic [7:0] memWrData;
  logic memWrite;
  logic halted;

  // program and data memory models
  logic [8:0] prog [256];
  logic [7:0] mem [256];
  int progPtr;
  int writeCount;
  int rstWrites;
  int testErrors;
  int passCount;
  int failCount;
  int propErrorsSeen;

  clockGen clockGen_i (.clk(clk), .porRst(porRst));

  assign rst = porRst | tbRst;
  assign instr = prog[pc];
  assign memRdData = mem[memAddr];

  accCore accCore_i (
    .clk(clk), .rst(rst), .instr(instr), .memRdData(memRdData), .pc(pc),
    .memAddr(memAddr), .memWrData(memWrData), .memWrite(memWrite), .halted(halted)
  );

  // memory captures at the edge
  always @(posedge clk) begin
    if (memWrite) begin
      mem[memAddr] <= memWrData;
      writeCount <= writeCount + 1;
      if (rst) rstWrites <= rstWrites + 1;
    end
  end

  function automatic logic [8:0] opWord(input logic [5:0] opc, input logic [1:0] a);
    accCorePkg::instrWord_t w;
    w.opView.opFlag = 1'b1;
    w.opView.opcode = opc;
    w.opView.arg = a;
    return w;
  endfunction

  task automatic emit(input logic [8:0] w);
    prog[progPtr] = w;
    progPtr++;
  endtask

  task automatic emitOp(input logic [5:0] opc, input logic [1:0] a);
    emit(opWord(opc, a));
  endtask

  // bit 8 low means t0 = imm
  task automatic emitSet(input logic [7:0] v);
    emit({1'b0, v});
  endtask

  task automatic clearProg();
    for (int i = 0; i < 256; i++) prog[i] = opWord(`ACC_OPC_HALT, 2'd0);
    progPtr = 0;
  endtask

  task automatic fillMem();
    for (int i = 0; i < 256; i++) mem[i] = 8'(i) ^ 8'h5A;
  endtask

  task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      testErrors++;
    end
  endtask

  // pulse rst and run until halted or timeout
  task automatic runProgram();
    int cycles;
    @(posedge clk);
    #5 tbRst = 1'b1;
    writeCount = 0;
    @(posedge clk);
    #5 tbRst = 1'b0;
    cycles = 0;
    while (!halted && cycles < 200) begin
      @(posedge clk);
      #5 cycles++;
    end
    assert (halted) else begin
      $display("core did not halt within 200 cycles");
      testErrors++;
    end
  endtask

  task automatic finishTest(input string name);
    testErrors += accCore_i.accCore_props_i.errorCount - propErrorsSeen;
    propErrorsSeen = accCore_i.accCore_props_i.errorCount;
    if (testErrors == 0) begin
      $display("test %s: pass", name);
      passCount++;
    end else begin
      $display("test %s: FAIL (%0d errors)", name, testErrors);
      failCount++;
    end
    testErrors = 0;
  endtask

  initial begin
    logic [7:0] v;
    logic [7:0] r;
    logic [7:0] m;
    logic [7:0] addr;
    logic [1:0] k;
    int n;
    int waitCycles;
    void'($urandom(20492));
    tbRst = 1'b0;
    writeCount = 0;
    rstWrites = 0;
    testErrors = 0;
    passCount = 0;
    failCount = 0;
    propErrorsSeen = 0;
    clearProg();
    fillMem();

    // reset with a store at pc 0 so the reset gating is exercised
    emitOp(`ACC_OPC_STM0, 2'd0);
    waitCycles = 0;
    while (porRst && waitCycles < 20) begin
      @(negedge clk);
      waitCycles++;
    end
    assert (!porRst) else begin
      $display("power-on reset never released");
      testErrors++;
    end
    checkByte("pc", pc, 8'h00);
    checkByte("halted", {7'd0, halted}, 8'h00);
    checkByte("rstWrites", 8'(rstWrites), 8'h00);
    finishTest("reset");

    // immediate, move and store
    v = 8'($urandom);
    clearProg();
    emitSet(v);
    emitOp(`ACC_OPC_MOV, 2'd1);
    emitOp(`ACC_OPC_LDR1, 2'd1);
    emitOp(`ACC_OPC_LDR5, 2'd0);
    emitSet(8'hB0);
    emitOp(`ACC_OPC_MOV, 2'd2);
    emitOp(`ACC_OPC_STM1, 2'd2);
    emitOp(`ACC_OPC_STR1, 2'd3);
    emitOp(`ACC_OPC_LDR4, 2'd3);
    emitSet(8'hB1);
    emitOp(`ACC_OPC_MOV, 2'd2);
    emitOp(`ACC_OPC_STM5, 2'd2);
    emitSet(8'hB2);
    emitOp(`ACC_OPC_MOV, 2'd2);
    emitOp(`ACC_OPC_STM4, 2'd2);
    runProgram();
    checkByte("mem[B0]", mem[8'hB0], v);
    checkByte("mem[B1]", mem[8'hB1], v);
    checkByte("mem[B2]", mem[8'hB2], v);
    finishTest("immediate");

    // load and arithmetic with the operand in t1 or t2
    fillMem();
    addr = 8'($urandom) & 8'h7F;
    r = 8'($urandom);
    k = 2'($urandom_range(2, 1));
    m = mem[addr];
    clearProg();
    emitSet(addr);
    emitOp(`ACC_OPC_MOV, 2'd1);
    emitOp(`ACC_OPC_LDM1, 2'd1);
    emitSet(r);
    emitOp(`ACC_OPC_MOV, k);
    emitOp(`ACC_OPC_ADD1, k);
    emitSet(8'hC0);
    emitOp(`ACC_OPC_MOV, 2'd3);
    emitOp(`ACC_OPC_STM1, 2'd3);
    emitOp(`ACC_OPC_SUB1, k);
    emitOp(`ACC_OPC_SUB1, k);
    emitSet(8'hC1);
    emitOp(`ACC_OPC_MOV, 2'd3);
    emitOp(`ACC_OPC_STM1, 2'd3);
    runProgram();
    checkByte("mem[C0]", mem[8'hC0], 8'(m + r));
    checkByte("mem[C1]", mem[8'hC1], 8'(m - r));
    finishTest("arithmetic");

    // shifts with the top bit set so sra differs from srl
    v = 8'($urandom) | 8'h80;
    clearProg();
    emitSet(v);
    emitOp(`ACC_OPC_MOV, 2'd1);
    emitOp(`ACC_OPC_SRL, 2'd1);
    emitOp(`ACC_OPC_LDR1, 2'd1);
    emitSet(8'hD0);
    emitOp(`ACC_OPC_MOV, 2'd3);
    emitOp(`ACC_OPC_STM1, 2'd3);
    emitSet(v);
    emitOp(`ACC_OPC_MOV, 2'd2);
    emitOp(`ACC_OPC_SRA, 2'd2);
    emitOp(`ACC_OPC_LDR4, 2'd2);
    emitSet(8'hD1);
    emitOp(`ACC_OPC_MOV, 2'd3);
    emitOp(`ACC_OPC_STM4, 2'd3);
    runProgram();
    checkByte("mem[D0]", mem[8'hD0], v >> 1);
    checkByte("mem[D1]", mem[8'hD1], (v >> 1) | 8'h80);
    finishTest("shifts");

    // countdown loop stores mem[i] = i on each pass
    fillMem();
    n = $urandom_range(8, 1);
    clearProg();
    emitSet(8'd1);
    emitOp(`ACC_OPC_MOV, 2'd2);
    emitSet(8'(n));
    emitOp(`ACC_OPC_LDR1, 2'd0);
    emitOp(`ACC_OPC_BNZR, 2'd0);
    progPtr = `ACC_BR_TARGET0;
    emitOp(`ACC_OPC_SUB1, 2'd2);
    emitOp(`ACC_OPC_STR1, 2'd3);
    emitOp(`ACC_OPC_STM1, 2'd3);
    emitOp(`ACC_OPC_STR1, 2'd0);
    emitOp(`ACC_OPC_BNZR, 2'd0);
    runProgram();
    checkByte("writeCount", 8'(writeCount), 8'(n));
    for (int i = 0; i < n; i++) checkByte("mem[i]", mem[i], 8'(i));
    finishTest("branch");

    // halt then present stores that must never fire
    clearProg();
    emitSet(8'h33);
    emitOp(`ACC_OPC_LDR4, 2'd0);
    emitSet(8'h40);
    emitOp(`ACC_OPC_MOV, 2'd1);
    emitOp(`ACC_OPC_HALT, 2'd0);
    emitOp(`ACC_OPC_STM4, 2'd1);
    emitOp(`ACC_OPC_STM4, 2'd1);
    runProgram();
    // a store now sits at the frozen pc
    prog[4] = opWord(`ACC_OPC_STM4, 2'd1);
    repeat (8) @(posedge clk);
    #5;
    checkByte("pc", pc, 8'h04);
    checkByte("halted", {7'd0, halted}, 8'h01);
    checkByte("writeCount", 8'(writeCount), 8'h00);
    finishTest("halt");

    $display("tests passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verification/clockGen.sv */
`timescale 1ns/1ns

module clockGen (
  output logic clk,
  output logic porRst
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // power-on reset for 4 cycles, released just after an edge
  initial begin
    porRst = 1'b1;
    repeat (4) @(posedge clk);
    #5 porRst = 1'b0;
  end

endmodule
